// File: logic/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// --------------------------------------
// Sizes
// --------------------------------------
`define DMA_NB_CORES     4
`define DMA_NB_STREAMS   2
`define DMA_ADDR_WIDTH   32
`define DMA_DATA_WIDTH   32
`define DMA_LEN_WIDTH    16
`define DMA_QUEUE_DEPTH  4
`define DMA_DATA_DEPTH   4

// Register map, byte offsets
`define DMA_REG_SRC      8'h00
`define DMA_REG_DST      8'h04
`define DMA_REG_LEN      8'h08
`define DMA_REG_CMD      8'h0C
`define DMA_REG_DONE0    8'h10
`define DMA_REG_DONE1    8'h14

`endif

// File: logic/dma_pkg.sv
`include "dma_params.svh"

package dma_pkg;

  // --------------------------------------
  // Transfer descriptor
  // --------------------------------------
  // Addresses are word addresses, len counts words
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] src;
    logic [`DMA_ADDR_WIDTH-1:0] dst;
    logic [`DMA_LEN_WIDTH-1:0]  len;
    logic                       stream;
  } dma_xfer_t;

  // --------------------------------------
  // Core configuration port
  // --------------------------------------
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [7:0]                 addr;
    logic [`DMA_DATA_WIDTH-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic [`DMA_DATA_WIDTH-1:0] rdata;
  } cfg_rsp_t;

  // --------------------------------------
  // Memory port, one per stream
  // --------------------------------------
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    logic [`DMA_DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic [`DMA_DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  typedef logic [31:0] done_cnt_t;

endpackage : dma_pkg

// File: logic/dma_fifo.sv
`timescale 1ns/100ps

module dma_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Producer and consumer both honour the buffer level
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i) valid_i |-> ready_o)
    else $error("dma_fifo: push while full");
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i) ready_i |-> valid_o)
    else $error("dma_fifo: pop while empty");

endmodule : dma_fifo

// File: logic/dma_cfg_regs.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_cfg_regs import dma_pkg::*; (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  cfg_req_t  [`DMA_NB_CORES-1:0]       cfg_req_i,
  output cfg_rsp_t  [`DMA_NB_CORES-1:0]       cfg_rsp_o,
  output dma_xfer_t                           xfer_o,
  output logic                                xfer_valid_o,
  input  logic      [`DMA_NB_STREAMS-1:0]     xfer_ready_i,
  input  done_cnt_t [`DMA_NB_STREAMS-1:0]     done_cnt_i
);

  localparam int IDX_W = $clog2(`DMA_NB_CORES);

  logic [`DMA_NB_CORES-1:0][`DMA_ADDR_WIDTH-1:0] src_q;
  logic [`DMA_NB_CORES-1:0][`DMA_ADDR_WIDTH-1:0] dst_q;
  logic [`DMA_NB_CORES-1:0][`DMA_LEN_WIDTH-1:0]  len_q;
  logic [`DMA_NB_CORES-1:0][`DMA_DATA_WIDTH-1:0] rdata_d;
  logic [`DMA_NB_CORES-1:0][`DMA_DATA_WIDTH-1:0] rdata_q;
  logic [`DMA_NB_CORES-1:0]                      rvalid_q;
  logic [`DMA_NB_CORES-1:0]                      cmd_wr;
  logic [`DMA_NB_CORES-1:0]                      gnt;
  logic [IDX_W-1:0]                              win_idx;
  logic                                          win_valid;
  logic                                          win_ok;
  logic                                          len_zero;

  // --------------------------------------
  // Command arbitration
  // --------------------------------------
  always_comb begin
    win_valid = 1'b0;
    win_idx   = '0;
    for (int i = `DMA_NB_CORES - 1; i >= 0; i--) begin
      cmd_wr[i] = cfg_req_i[i].req && cfg_req_i[i].we && (cfg_req_i[i].addr == `DMA_REG_CMD);
      if (cmd_wr[i]) begin
        win_valid = 1'b1;
        win_idx   = IDX_W'(i);
      end
    end
  end

  // Descriptor from the winner's shadow set
  assign xfer_o.src    = src_q[win_idx];
  assign xfer_o.dst    = dst_q[win_idx];
  assign xfer_o.len    = len_q[win_idx];
  assign xfer_o.stream = cfg_req_i[win_idx].wdata[0];

  assign len_zero     = (xfer_o.len == '0);
  assign win_ok       = win_valid && (len_zero || xfer_ready_i[xfer_o.stream]);
  assign xfer_valid_o = win_ok && !len_zero;

  always_comb begin
    for (int i = 0; i < `DMA_NB_CORES; i++) begin
      if (cmd_wr[i]) begin
        gnt[i] = win_ok && (win_idx == IDX_W'(i));
      end else begin
        gnt[i] = cfg_req_i[i].req;
      end
      case (cfg_req_i[i].addr)
        `DMA_REG_SRC:   rdata_d[i] = src_q[i];
        `DMA_REG_DST:   rdata_d[i] = dst_q[i];
        `DMA_REG_LEN:   rdata_d[i] = `DMA_DATA_WIDTH'(len_q[i]);
        `DMA_REG_DONE0: rdata_d[i] = done_cnt_i[0];
        `DMA_REG_DONE1: rdata_d[i] = done_cnt_i[1];
        default:        rdata_d[i] = '0;
      endcase
    end
  end

  // --------------------------------------
  // Shadow registers and responses
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `DMA_NB_CORES; i++) begin
      if (cfg_req_i[i].req && cfg_req_i[i].we && (cfg_req_i[i].addr == `DMA_REG_SRC)) begin
        src_q[i] <= cfg_req_i[i].wdata;
      end
      if (cfg_req_i[i].req && cfg_req_i[i].we && (cfg_req_i[i].addr == `DMA_REG_DST)) begin
        dst_q[i] <= cfg_req_i[i].wdata;
      end
      rdata_q[i] <= rdata_d[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_q    <= '0;
      rvalid_q <= '0;
    end else begin
      rvalid_q <= gnt;
      for (int i = 0; i < `DMA_NB_CORES; i++) begin
        if (cfg_req_i[i].req && cfg_req_i[i].we && (cfg_req_i[i].addr == `DMA_REG_LEN)) begin
          len_q[i] <= cfg_req_i[i].wdata[`DMA_LEN_WIDTH-1:0];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `DMA_NB_CORES; i++) begin
      cfg_rsp_o[i].gnt    = gnt[i];
      cfg_rsp_o[i].rvalid = rvalid_q[i];
      cfg_rsp_o[i].rdata  = rdata_q[i];
    end
  end

  a_one_cmd: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt & cmd_wr))
    else $error("dma_cfg_regs: more than one command granted");

endmodule : dma_cfg_regs

// File: logic/dma_dispatch.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_dispatch import dma_pkg::*; (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  dma_xfer_t                           xfer_i,
  input  logic                                xfer_valid_i,
  output logic      [`DMA_NB_STREAMS-1:0]     xfer_ready_o,
  output dma_xfer_t [`DMA_NB_STREAMS-1:0]     stream_xfer_o,
  output logic      [`DMA_NB_STREAMS-1:0]     stream_valid_o,
  input  logic      [`DMA_NB_STREAMS-1:0]     stream_ready_i
);

  // --------------------------------------
  // One request queue per stream
  // --------------------------------------
  for (genvar s = 0; s < `DMA_NB_STREAMS; s++) begin : gen_queue
    logic push_valid;

    // Stream bit picks the queue
    assign push_valid = xfer_valid_i && (xfer_i.stream == 1'(s));

    dma_fifo #(
      .T     ( dma_xfer_t       ),
      .DEPTH ( `DMA_QUEUE_DEPTH )
    ) u_queue (
      .clk_i   ( clk_i             ),
      .reset_i ( reset_i           ),
      .data_i  ( xfer_i            ),
      .valid_i ( push_valid        ),
      .ready_o ( xfer_ready_o[s]   ),
      .data_o  ( stream_xfer_o[s]  ),
      .valid_o ( stream_valid_o[s] ),
      .ready_i ( stream_ready_i[s] )
    );
  end

endmodule : dma_dispatch

// File: logic/dma_stream_engine.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_stream_engine import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  dma_xfer_t xfer_i,
  input  logic      xfer_valid_i,
  output logic      xfer_ready_o,
  output mem_req_t  mem_req_o,
  input  mem_rsp_t  mem_rsp_i,
  output logic      done_o,
  output logic      busy_o
);

  localparam int CNT_W = $clog2(`DMA_DATA_DEPTH + 1);

  logic                       active_q;
  logic [`DMA_ADDR_WIDTH-1:0] rd_addr_q;
  logic [`DMA_ADDR_WIDTH-1:0] wr_addr_q;
  logic [`DMA_LEN_WIDTH-1:0]  rd_left_q;
  logic [`DMA_LEN_WIDTH-1:0]  wr_left_q;
  logic [CNT_W-1:0]           credit_q;  // read granted, not yet written
  logic [CNT_W-1:0]           pend_q;    // read granted, data not back
  logic                       rd_hold_q;
  logic [`DMA_DATA_WIDTH-1:0] buf_data;
  logic                       buf_valid;
  logic                       start;
  logic                       rd_ok;
  logic                       sel_wr;
  logic                       sel_rd;
  logic                       rd_gnt;
  logic                       wr_gnt;

  dma_fifo #(
    .T     ( logic [`DMA_DATA_WIDTH-1:0] ),
    .DEPTH ( `DMA_DATA_DEPTH             )
  ) u_data_buf (
    .clk_i   ( clk_i            ),
    .reset_i ( reset_i          ),
    .data_i  ( mem_rsp_i.rdata  ),
    .valid_i ( mem_rsp_i.rvalid ),
    .ready_o (                  ),
    .data_o  ( buf_data         ),
    .valid_o ( buf_valid        ),
    .ready_i ( wr_gnt           )
  );

  // --------------------------------------
  // Port selection
  // --------------------------------------
  // Pull a descriptor only when one is waiting
  assign xfer_ready_o = !active_q && xfer_valid_i;
  assign start        = xfer_valid_i && xfer_ready_o;

  // No read unless its word has room in the buffer
  assign rd_ok  = active_q && (rd_left_q != '0) && (credit_q != CNT_W'(`DMA_DATA_DEPTH));
  // Writes win, but an ungranted read stays on the port
  assign sel_wr = active_q && buf_valid && !rd_hold_q;
  assign sel_rd = !sel_wr && rd_ok;
  assign rd_gnt = sel_rd && mem_rsp_i.gnt;
  assign wr_gnt = sel_wr && mem_rsp_i.gnt;

  assign mem_req_o.req   = sel_wr || sel_rd;
  assign mem_req_o.we    = sel_wr;
  assign mem_req_o.addr  = sel_wr ? wr_addr_q : rd_addr_q;
  assign mem_req_o.wdata = buf_data;

  assign done_o = wr_gnt && (wr_left_q == `DMA_LEN_WIDTH'(1));
  assign busy_o = active_q;

  // --------------------------------------
  // Progress counters
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      rd_left_q <= '0;
      wr_left_q <= '0;
      credit_q  <= '0;
      pend_q    <= '0;
      rd_hold_q <= 1'b0;
    end else begin
      rd_hold_q <= sel_rd && !mem_rsp_i.gnt;
      if (start) begin
        active_q  <= 1'b1;
        rd_left_q <= xfer_i.len;
        wr_left_q <= xfer_i.len;
      end else begin
        if (rd_gnt) begin
          rd_left_q <= rd_left_q - `DMA_LEN_WIDTH'(1);
        end
        if (wr_gnt) begin
          wr_left_q <= wr_left_q - `DMA_LEN_WIDTH'(1);
        end
        if (done_o) begin
          active_q <= 1'b0;
        end
      end
      if (rd_gnt) begin
        credit_q <= credit_q + CNT_W'(1);
      end else if (wr_gnt) begin
        credit_q <= credit_q - CNT_W'(1);
      end
      case ({rd_gnt, mem_rsp_i.rvalid})
        2'b10:   pend_q <= pend_q + CNT_W'(1);
        2'b01:   pend_q <= pend_q - CNT_W'(1);
        default: pend_q <= pend_q;
      endcase
    end
  end

  // Word addresses step by one per grant
  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_addr_q <= xfer_i.src;
      wr_addr_q <= xfer_i.dst;
    end else begin
      if (rd_gnt) begin
        rd_addr_q <= rd_addr_q + `DMA_ADDR_WIDTH'(1);
      end
      if (wr_gnt) begin
        wr_addr_q <= wr_addr_q + `DMA_ADDR_WIDTH'(1);
      end
    end
  end

  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rsp_i.rvalid |-> (pend_q != '0))
    else $error("dma_stream_engine: read data with no read outstanding");

endmodule : dma_stream_engine

// File: logic/dma_completion.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_completion import dma_pkg::*; (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic      [`DMA_NB_STREAMS-1:0]     done_i,
  input  logic      [`DMA_NB_STREAMS-1:0]     engine_busy_i,
  output done_cnt_t [`DMA_NB_STREAMS-1:0]     done_cnt_o,
  output logic      [`DMA_NB_CORES-1:0]       term_event_o,
  output logic                                busy_o
);

  done_cnt_t [`DMA_NB_STREAMS-1:0] cnt_q;
  logic      [2:0]                 owed_q;
  logic      [2:0]                 events;
  logic                            term_q;

  // Completions in the same cycle go out as back-to-back events
  always_comb begin
    events = owed_q;
    for (int s = 0; s < `DMA_NB_STREAMS; s++) begin
      events = events + 3'(done_i[s]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      owed_q <= '0;
      term_q <= 1'b0;
    end else begin
      for (int s = 0; s < `DMA_NB_STREAMS; s++) begin
        if (done_i[s]) begin
          cnt_q[s] <= cnt_q[s] + 32'd1;
        end
      end
      term_q <= (events != '0);
      owed_q <= (events != '0) ? events - 3'd1 : '0;
    end
  end

  assign done_cnt_o   = cnt_q;
  assign term_event_o = {`DMA_NB_CORES{term_q}};
  assign busy_o       = |engine_busy_i;

endmodule : dma_completion

// File: logic/dma_ctrl.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_ctrl import dma_pkg::*; (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  cfg_req_t [`DMA_NB_CORES-1:0]    cfg_req_i,
  output cfg_rsp_t [`DMA_NB_CORES-1:0]    cfg_rsp_o,
  output mem_req_t [`DMA_NB_STREAMS-1:0]  mem_req_o,
  input  mem_rsp_t [`DMA_NB_STREAMS-1:0]  mem_rsp_i,
  output logic     [`DMA_NB_CORES-1:0]    term_event_o,
  output logic                            busy_o
);

  dma_xfer_t                       xfer;
  logic                            xfer_valid;
  logic      [`DMA_NB_STREAMS-1:0] xfer_ready;
  done_cnt_t [`DMA_NB_STREAMS-1:0] done_cnt;
  dma_xfer_t [`DMA_NB_STREAMS-1:0] stream_xfer;
  logic      [`DMA_NB_STREAMS-1:0] stream_valid;
  logic      [`DMA_NB_STREAMS-1:0] stream_ready;
  logic      [`DMA_NB_STREAMS-1:0] eng_done;
  logic      [`DMA_NB_STREAMS-1:0] eng_busy;

  // --------------------------------------
  // Frontend and request queues
  // --------------------------------------
  dma_cfg_regs u_cfg_regs (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .cfg_req_i    ( cfg_req_i  ),
    .cfg_rsp_o    ( cfg_rsp_o  ),
    .xfer_o       ( xfer       ),
    .xfer_valid_o ( xfer_valid ),
    .xfer_ready_i ( xfer_ready ),
    .done_cnt_i   ( done_cnt   )
  );

  dma_dispatch u_dispatch (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .xfer_i         ( xfer         ),
    .xfer_valid_i   ( xfer_valid   ),
    .xfer_ready_o   ( xfer_ready   ),
    .stream_xfer_o  ( stream_xfer  ),
    .stream_valid_o ( stream_valid ),
    .stream_ready_i ( stream_ready )
  );

  // --------------------------------------
  // Stream engines
  // --------------------------------------
  for (genvar s = 0; s < `DMA_NB_STREAMS; s++) begin : gen_engine
    dma_stream_engine u_engine (
      .clk_i        ( clk_i           ),
      .reset_i      ( reset_i         ),
      .xfer_i       ( stream_xfer[s]  ),
      .xfer_valid_i ( stream_valid[s] ),
      .xfer_ready_o ( stream_ready[s] ),
      .mem_req_o    ( mem_req_o[s]    ),
      .mem_rsp_i    ( mem_rsp_i[s]    ),
      .done_o       ( eng_done[s]     ),
      .busy_o       ( eng_busy[s]     )
    );
  end

  dma_completion u_completion (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .done_i        ( eng_done     ),
    .engine_busy_i ( eng_busy     ),
    .done_cnt_o    ( done_cnt     ),
    .term_event_o  ( term_event_o ),
    .busy_o        ( busy_o       )
  );

endmodule : dma_ctrl

// File: verification/dma_mem_model.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_mem_model import dma_pkg::*; #(
  parameter int WORDS = 256,
  parameter int SEED  = 85331
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       hold_i,
  input  logic                       load_i,
  input  logic [$clog2(WORDS)-1:0]   load_addr_i,
  input  logic [`DMA_DATA_WIDTH-1:0] load_data_i,
  input  mem_req_t                   mem_req_i,
  output mem_rsp_t                   mem_rsp_o
);

  localparam int AW = $clog2(WORDS);

  logic [`DMA_DATA_WIDTH-1:0] mem_q [WORDS];
  logic [`DMA_DATA_WIDTH-1:0] rdata_q;
  logic                       rvalid_q;
  logic                       open_q;
  logic [AW-1:0]              idx;
  integer                     seed = SEED;

  assign idx              = mem_req_i.addr[AW-1:0];
  assign mem_rsp_o.gnt    = mem_req_i.req && open_q && !hold_i;
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

  // Grant window drawn fresh every cycle, open three times in four
  always @(posedge clk_i) begin
    open_q <= (($random(seed) & 32'd3) != 32'd0);
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem_rsp_o.gnt && !mem_req_i.we;
    end
    if (mem_rsp_o.gnt && !mem_req_i.we) begin
      rdata_q <= mem_q[idx];
    end
    // Backdoor load during setup
    if (load_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end else if (mem_rsp_o.gnt && mem_req_i.we) begin
      mem_q[idx] <= mem_req_i.wdata;
    end
  end

endmodule : dma_mem_model

// File: verification/dma_ctrl_tb.sv
`timescale 1ns/100ps

`include "dma_params.svh"

module dma_ctrl_tb import dma_pkg::*; ();

  localparam int MEM_WORDS   = 256;
  localparam int TOTAL_WORDS = 8 + 12 + 10 + 4 * 5 + 6 * 3;
  localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 500;

  logic                             clk;
  logic                             reset;
  cfg_req_t [`DMA_NB_CORES-1:0]     cfg_req;
  cfg_rsp_t [`DMA_NB_CORES-1:0]     cfg_rsp;
  mem_req_t [`DMA_NB_STREAMS-1:0]   mem_req;
  mem_rsp_t [`DMA_NB_STREAMS-1:0]   mem_rsp;
  logic     [`DMA_NB_CORES-1:0]     term_event;
  logic                             busy;
  logic     [`DMA_NB_STREAMS-1:0]   hold;
  logic                             load;
  logic     [7:0]                   load_addr;
  logic     [31:0]                  load_data0;
  logic     [31:0]                  load_data1;
  integer                           seed = 85331;
  logic     [31:0]                  shadow [2][MEM_WORDS];
  int                               core_src [`DMA_NB_CORES];
  int                               core_dst [`DMA_NB_CORES];
  int                               core_len [`DMA_NB_CORES];
  int                               exp_done [2];
  int                               term_count = 0;
  int                               cycles = 0;
  logic                             overlap_seen = 1'b0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  dma_ctrl u_dma_ctrl (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .cfg_req_i    ( cfg_req    ),
    .cfg_rsp_o    ( cfg_rsp    ),
    .mem_req_o    ( mem_req    ),
    .mem_rsp_i    ( mem_rsp    ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  dma_mem_model u_mem0 (
    .clk_i       ( clk        ),
    .reset_i     ( reset      ),
    .hold_i      ( hold[0]    ),
    .load_i      ( load       ),
    .load_addr_i ( load_addr  ),
    .load_data_i ( load_data0 ),
    .mem_req_i   ( mem_req[0] ),
    .mem_rsp_o   ( mem_rsp[0] )
  );

  dma_mem_model u_mem1 (
    .clk_i       ( clk        ),
    .reset_i     ( reset      ),
    .hold_i      ( hold[1]    ),
    .load_i      ( load       ),
    .load_addr_i ( load_addr  ),
    .load_data_i ( load_data1 ),
    .mem_req_i   ( mem_req[1] ),
    .mem_rsp_o   ( mem_rsp[1] )
  );

  // --------------------------------------
  // Checks and reference model
  // --------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Expected memory after one descriptor
  function automatic void copy_ref(input int s, input int src, input int dst, input int len);
    for (int i = 0; i < len; i++) begin
      shadow[s][dst + i] = shadow[s][src + i];
    end
  endfunction

  task automatic compare_memory(input string name);
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_value({name, " stream0 mem"}, shadow[0][a], u_mem0.mem_q[a]);
      check_value({name, " stream1 mem"}, shadow[1][a], u_mem1.mem_q[a]);
    end
  endtask

  always @(posedge clk) begin
    if (!reset && term_event != '0) begin
      check_value("term_event all cores", 32'hF, 32'(term_event));
      term_count <= term_count + 1;
    end
    if (mem_req[0].req && mem_req[1].req) begin
      overlap_seen <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, transfers did not finish", cycles);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------
  // Bus tasks
  // --------------------------------------
  task automatic write_reg(input int core, input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    cfg_req[core] <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    while (!cfg_rsp[core].gnt) @(posedge clk);
    cfg_req[core].req <= 1'b0;
    @(posedge clk);
    check_value("write rvalid", 32'd1, 32'(cfg_rsp[core].rvalid));
  endtask

  task automatic read_reg(input int core, input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    cfg_req[core] <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge clk);
    while (!cfg_rsp[core].gnt) @(posedge clk);
    cfg_req[core].req <= 1'b0;
    @(posedge clk);
    check_value("read rvalid", 32'd1, 32'(cfg_rsp[core].rvalid));
    data = cfg_rsp[core].rdata;
  endtask

  task automatic set_regs(input int core, input int src, input int dst, input int len);
    core_src[core] = src;
    core_dst[core] = dst;
    core_len[core] = len;
    write_reg(core, `DMA_REG_SRC, 32'(src));
    write_reg(core, `DMA_REG_DST, 32'(dst));
    write_reg(core, `DMA_REG_LEN, 32'(len));
  endtask

  // All masked cores raise CMD together; lowest pending index must win
  task automatic issue_cmds(input string name, input logic [3:0] mask, input logic [3:0] streams);
    logic [3:0] pending;
    logic [3:0] gnt;
    logic [3:0] prev_gnt;
    logic [3:0] rv;
    logic [3:0] lowest;
    pending  = mask;
    prev_gnt = '0;
    @(posedge clk);
    for (int c = 0; c < `DMA_NB_CORES; c++) begin
      if (mask[c]) begin
        cfg_req[c] <= '{req: 1'b1, we: 1'b1, addr: `DMA_REG_CMD, wdata: {31'b0, streams[c]}};
      end
    end
    while (pending != '0 || prev_gnt != '0) begin
      @(posedge clk);
      for (int c = 0; c < `DMA_NB_CORES; c++) begin
        gnt[c] = cfg_rsp[c].gnt;
        rv[c]  = cfg_rsp[c].rvalid;
      end
      check_value({name, " rvalid"}, 32'(prev_gnt), 32'(rv));
      lowest = pending & (~pending + 4'd1);
      if (gnt != '0) begin
        check_value({name, " gnt order"}, 32'(lowest), 32'(gnt));
      end
      for (int c = 0; c < `DMA_NB_CORES; c++) begin
        if (gnt[c]) begin
          cfg_req[c].req <= 1'b0;
          if (core_len[c] != 0) begin
            copy_ref(int'(streams[c]), core_src[c], core_dst[c], core_len[c]);
            exp_done[streams[c]]++;
          end
        end
      end
      pending  = pending & ~gnt;
      prev_gnt = gnt;
    end
  endtask

  task automatic wait_counts(input string name);
    logic [31:0] d0;
    logic [31:0] d1;
    read_reg(3, `DMA_REG_DONE0, d0);
    read_reg(3, `DMA_REG_DONE1, d1);
    while (d0 < 32'(exp_done[0]) || d1 < 32'(exp_done[1])) begin
      read_reg(3, `DMA_REG_DONE0, d0);
      read_reg(3, `DMA_REG_DONE1, d1);
    end
    check_value({name, " DONE0"}, 32'(exp_done[0]), d0);
    check_value({name, " DONE1"}, 32'(exp_done[1]), d1);
  endtask

  task automatic preload();
    logic [31:0] d0;
    logic [31:0] d1;
    for (int a = 0; a < MEM_WORDS; a++) begin
      d0 = $random(seed);
      d1 = $random(seed);
      shadow[0][a] = d0;
      shadow[1][a] = d1;
      @(posedge clk);
      load       <= 1'b1;
      load_addr  <= 8'(a);
      load_data0 <= d0;
      load_data1 <= d1;
    end
    @(posedge clk);
    load <= 1'b0;
  endtask

  // --------------------------------------
  // Test sequence
  // --------------------------------------
  initial begin : main_flow
    logic [31:0] rd;
    reset      <= 1'b1;
    cfg_req    <= '0;
    hold       <= '0;
    load       <= 1'b0;
    load_addr  <= '0;
    load_data0 <= '0;
    load_data1 <= '0;
    exp_done   = '{0, 0};
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value("reset busy", 32'd0, 32'(busy));
    check_value("reset term_event", 32'd0, 32'(term_event));
    check_value("reset mem req", 32'd0, 32'({mem_req[1].req, mem_req[0].req}));
    check_value("reset cfg rvalid", 32'd0, 32'({cfg_rsp[3].rvalid, cfg_rsp[2].rvalid,
                                               cfg_rsp[1].rvalid, cfg_rsp[0].rvalid}));
    read_reg(3, `DMA_REG_DONE0, rd);
    check_value("reset DONE0", 32'd0, rd);
    read_reg(3, `DMA_REG_DONE1, rd);
    check_value("reset DONE1", 32'd0, rd);
    preload();

    // Single transfer on stream 0
    set_regs(0, 'h00, 'h80, 8);
    issue_cmds("t1 cmd", 4'b0001, 4'b0000);
    wait_counts("t1");
    compare_memory("t1");

    // Both streams at once
    set_regs(1, 'h10, 'h90, 12);
    set_regs(2, 'h20, 'hA0, 10);
    issue_cmds("t2 cmd", 4'b0110, 4'b0010);
    wait_counts("t2");
    compare_memory("t2");
    check_value("t2 overlap", 32'd1, 32'(overlap_seen));

    // Four cores in the same cycle
    for (int c = 0; c < `DMA_NB_CORES; c++) begin
      set_regs(c, 'h30 + 8 * c, 'hB0 + 8 * c, 5);
    end
    issue_cmds("t3 cmd", 4'b1111, 4'b1010);
    wait_counts("t3");
    compare_memory("t3");

    // Queue fills while memory withholds gnt
    set_regs(0, 'h60, 'hE0, 3);
    @(posedge clk);
    hold[0] <= 1'b1;
    repeat (5) issue_cmds("t4 cmd", 4'b0001, 4'b0000);
    @(posedge clk);
    cfg_req[0] <= '{req: 1'b1, we: 1'b1, addr: `DMA_REG_CMD, wdata: '0};
    repeat (8) begin
      @(posedge clk);
      check_value("t4 full gnt", 32'd0, 32'(cfg_rsp[0].gnt));
    end
    hold[0] <= 1'b0;
    @(posedge clk);
    while (!cfg_rsp[0].gnt) @(posedge clk);
    cfg_req[0].req <= 1'b0;
    copy_ref(0, 'h60, 'hE0, 3);
    exp_done[0]++;
    wait_counts("t4");
    compare_memory("t4");

    // Zero length is granted and dropped
    set_regs(2, 'h40, 'hF0, 0);
    issue_cmds("t5 cmd", 4'b0100, 4'b0100);
    repeat (20) @(posedge clk);
    wait_counts("t5");
    compare_memory("t5");

    // Event count and idle level
    repeat (4) @(posedge clk);
    check_value("t6 term count", 32'(exp_done[0] + exp_done[1]), 32'(term_count));
    check_value("t6 busy", 32'd0, 32'(busy));
    $display(">>> PASS");
    $finish;
  end

endmodule : dma_ctrl_tb

// File: build.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_fifo.sv
logic/dma_cfg_regs.sv
logic/dma_dispatch.sv
logic/dma_stream_engine.sv
logic/dma_completion.sv
logic/dma_ctrl.sv
verification/dma_mem_model.sv
verification/dma_ctrl_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f build.f \
		--top-module dma_ctrl_tb --Mdir obj_dir -o dma_ctrl_tb
	./obj_dir/dma_ctrl_tb

clean:
	rm -rf obj_dir
